// File: filelist.f
source/lsu_pkg.sv
source/lsu_fsm.sv
source/lsu_addr_gen.sv
source/lsu_wdata_align.sv
source/lsu_rdata_align.sv
source/load_store_unit.sv
verif/tb_clk_gen.sv
verif/tb_load_store_unit.sv

// File: source/load_store_unit.sv
/* Load/store unit top; word bus with req/gnt/rvalid, in-order responses.
   Misaligned accesses are split into two word accesses. */
`timescale 1ns/10ps

module load_store_unit (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // execute stage
  input  logic                      lsu_req_i,
  input  logic                      lsu_we_i,
  input  lsu_pkg::lsu_type_e        lsu_type_i,
  input  logic                      lsu_sign_ext_i,
  input  logic [lsu_pkg::AddrW-1:0] lsu_addr_i,
  input  logic [lsu_pkg::DataW-1:0] lsu_wdata_i,
  input  logic                      ds_rdy_i,
  output logic                      lsu_req_done_o,
  output logic                      lsu_resp_valid_o,
  output logic                      lsu_resp_err_o,
  output logic [lsu_pkg::DataW-1:0] lsu_rdata_o,
  output logic [5:0]                lsu_mcause_o,
  output logic [lsu_pkg::AddrW-1:0] lsu_mtval_o,
  output logic [lsu_pkg::AddrW-1:0] addr_last_o,
  output logic                      busy_o,
  // data bus
  output logic                      data_req_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  input  logic                      data_err_i,
  input  logic                      data_pmp_err_i,
  output logic [lsu_pkg::AddrW-1:0] data_addr_o,
  output logic                      data_we_o,
  output logic [lsu_pkg::BeW-1:0]   data_be_o,
  output logic [lsu_pkg::DataW-1:0] data_wdata_o,
  input  logic [lsu_pkg::DataW-1:0] data_rdata_i
);

  logic                      handle_misaligned;
  logic                      addr_incr;
  logic                      ctrl_update;
  logic                      addr_update;
  logic                      rdata_update;
  logic [1:0]                data_offset;
  logic [lsu_pkg::AddrW-1:0] addr_last;

  lsu_fsm i_fsm (
    .clk_i, .rst_ni, .lsu_req_i, .lsu_we_i, .lsu_type_i, .ds_rdy_i,
    .data_offset_i       (data_offset),
    .data_gnt_i, .data_rvalid_i, .data_err_i, .data_pmp_err_i, .data_req_o,
    .handle_misaligned_o (handle_misaligned),
    .addr_incr_o         (addr_incr),
    .ctrl_update_o       (ctrl_update),
    .addr_update_o       (addr_update),
    .rdata_update_o      (rdata_update),
    .lsu_req_done_o, .lsu_resp_valid_o, .lsu_resp_err_o, .lsu_mcause_o, .busy_o
  );

  lsu_addr_gen i_addr_gen (
    .clk_i, .rst_ni, .lsu_addr_i,
    .handle_misaligned_i (handle_misaligned),
    .addr_incr_i         (addr_incr),
    .addr_update_i       (addr_update),
    .data_addr_o,
    .data_offset_o       (data_offset),
    .addr_last_o         (addr_last)
  );

  lsu_wdata_align i_wdata_align (
    .lsu_type_i, .handle_misaligned_i (handle_misaligned),
    .data_offset_i (data_offset), .lsu_wdata_i, .data_be_o, .data_wdata_o
  );

  lsu_rdata_align i_rdata_align (
    .clk_i, .rst_ni,
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .data_offset_i  (data_offset),
    .lsu_type_i, .lsu_sign_ext_i, .data_rdata_i, .lsu_rdata_o
  );

  assign data_we_o   = lsu_we_i;
  assign lsu_mtval_o = addr_last;
  assign addr_last_o = addr_last;

  // FSM part tracking and enable tables together never issue an empty access
  a_be_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> (data_be_o != '0));

endmodule

// File: source/lsu_addr_gen.sv
/* Bus address generation; the second part of a split access is the next word.
   addr_last_o holds the failing address after an error. */
`timescale 1ns/10ps

module lsu_addr_gen (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [lsu_pkg::AddrW-1:0] lsu_addr_i,
  input  logic                      handle_misaligned_i,
  input  logic                      addr_incr_i,
  input  logic                      addr_update_i,
  output logic [lsu_pkg::AddrW-1:0] data_addr_o,
  output logic [1:0]                data_offset_o,
  output logic [lsu_pkg::AddrW-1:0] addr_last_o
);

  logic [lsu_pkg::AddrW-1:0] addr_first_q;
  logic [lsu_pkg::AddrW-1:0] data_addr;
  logic [lsu_pkg::AddrW-1:0] data_addr_w_aligned;
  logic [lsu_pkg::AddrW-1:0] addr_last_q;

  // first address of the request, kept for the second part
  always_ff @(posedge clk_i) begin
    if (addr_update_i && !handle_misaligned_i) begin
      addr_first_q <= lsu_addr_i;
    end
  end

  // next word while the second part is pending or in flight
  assign data_addr = addr_incr_i ?
                     addr_first_q + {{(lsu_pkg::AddrW-3){1'b0}}, 3'b100} :
                     lsu_addr_i;

  assign data_addr_w_aligned = {data_addr[lsu_pkg::AddrW-1:2], 2'b00};

  // second part reports its word-aligned address
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update_i) begin
      addr_last_q <= addr_incr_i ? data_addr_w_aligned : data_addr;
    end
  end

  assign data_addr_o   = data_addr_w_aligned;
  assign data_offset_o = data_addr[1:0];
  assign addr_last_o   = addr_last_q;

endmodule

// File: source/lsu_fsm.sv
/* Request sequencer; one request and one outstanding response at most.
   Request fields must stay stable until lsu_req_done_o. */
`timescale 1ns/10ps

module lsu_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                lsu_req_i,
  input  logic                lsu_we_i,
  input  lsu_pkg::lsu_type_e  lsu_type_i,
  input  logic                ds_rdy_i,
  input  logic [1:0]          data_offset_i,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  input  logic                data_err_i,
  input  logic                data_pmp_err_i,
  output logic                data_req_o,
  output logic                handle_misaligned_o,
  output logic                addr_incr_o,
  output logic                ctrl_update_o,
  output logic                addr_update_o,
  output logic                rdata_update_o,
  output logic                lsu_req_done_o,
  output logic                lsu_resp_valid_o,
  output logic                lsu_resp_err_o,
  output logic [5:0]          lsu_mcause_o,
  output logic                busy_o
);

  lsu_pkg::ls_fsm_e ls_fsm_cs, ls_fsm_ns;

  logic split_access;
  logic handle_misaligned_q, handle_misaligned_d;
  logic pmp_err_q, pmp_err_d;
  logic lsu_err_q, lsu_err_d;
  logic we_q;
  logic outstanding_resp_q;
  logic resp_wait;
  logic resp_valid;
  logic any_err;
  logic lsu_go;

  // word at any nonzero offset, or half word crossing into the next word
  assign split_access = ((lsu_type_i == lsu_pkg::WORD) && (data_offset_i != 2'b00)) ||
                        ((lsu_type_i == lsu_pkg::HALF) && (data_offset_i == 2'b11));

  always_comb begin
    ls_fsm_ns           = ls_fsm_cs;
    data_req_o          = 1'b0;
    addr_incr_o         = 1'b0;
    ctrl_update_o       = 1'b0;
    addr_update_o       = 1'b0;
    rdata_update_o      = 1'b0;
    handle_misaligned_d = handle_misaligned_q;
    pmp_err_d           = pmp_err_q;
    lsu_err_d           = lsu_err_q;
    lsu_go              = 1'b0;

    unique case (ls_fsm_cs)
      lsu_pkg::IDLE: begin
        pmp_err_d = 1'b0;
        if (lsu_req_i && !resp_wait && ds_rdy_i) begin
          lsu_go     = 1'b1;
          data_req_o = 1'b1;
          pmp_err_d  = data_pmp_err_i;
          lsu_err_d  = 1'b0;
          if (data_gnt_i) begin
            ctrl_update_o       = 1'b1;
            addr_update_o       = 1'b1;
            handle_misaligned_d = split_access;
            ls_fsm_ns = split_access ? lsu_pkg::WAIT_RVALID_MIS : lsu_pkg::IDLE;
          end else begin
            ls_fsm_ns = split_access ? lsu_pkg::WAIT_GNT_MIS : lsu_pkg::WAIT_GNT;
          end
        end
      end

      lsu_pkg::WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        // a PMP error blocks the bus, so it stands in for the grant
        if (data_gnt_i || pmp_err_q) begin
          ctrl_update_o       = 1'b1;
          addr_update_o       = 1'b1;
          handle_misaligned_d = 1'b1;
          ls_fsm_ns           = lsu_pkg::WAIT_RVALID_MIS;
        end
      end

      lsu_pkg::WAIT_RVALID_MIS: begin
        // second part goes out while the first response is awaited
        data_req_o  = 1'b1;
        addr_incr_o = 1'b1;
        if (data_rvalid_i || pmp_err_q) begin
          pmp_err_d           = data_pmp_err_i;
          lsu_err_d           = data_err_i | pmp_err_q;
          rdata_update_o      = ~we_q;
          addr_update_o       = data_gnt_i & ~(data_err_i | pmp_err_q);
          handle_misaligned_d = ~data_gnt_i;
          ls_fsm_ns = data_gnt_i ? lsu_pkg::IDLE : lsu_pkg::WAIT_GNT;
        end else if (data_gnt_i) begin
          // second grant came before the first rvalid
          handle_misaligned_d = 1'b0;
          ls_fsm_ns           = lsu_pkg::WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      lsu_pkg::WAIT_GNT: begin
        data_req_o  = 1'b1;
        addr_incr_o = handle_misaligned_q;
        if (data_gnt_i || pmp_err_q) begin
          ctrl_update_o       = 1'b1;
          addr_update_o       = ~lsu_err_q;  // keep the first failing address
          handle_misaligned_d = 1'b0;
          ls_fsm_ns           = lsu_pkg::IDLE;
        end
      end

      lsu_pkg::WAIT_RVALID_MIS_GNTS_DONE: begin
        addr_incr_o = 1'b1;
        if (data_rvalid_i) begin
          pmp_err_d      = data_pmp_err_i;
          lsu_err_d      = data_err_i;
          addr_update_o  = ~data_err_i;
          rdata_update_o = ~we_q;
          ls_fsm_ns      = lsu_pkg::IDLE;
        end
      end

      default: ls_fsm_ns = lsu_pkg::IDLE;
    endcase
  end

  //////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////

  assign any_err    = lsu_err_q | data_err_i | pmp_err_q;
  assign resp_valid = (data_rvalid_i | pmp_err_q) & (ls_fsm_cs == lsu_pkg::IDLE);
  // stall new requests behind a pending or failing response
  assign resp_wait  = outstanding_resp_q & (~resp_valid | any_err);

  assign lsu_req_done_o      = (lsu_go | (ls_fsm_cs != lsu_pkg::IDLE)) &
                               (ls_fsm_ns == lsu_pkg::IDLE);
  assign lsu_resp_valid_o    = resp_valid;
  assign lsu_resp_err_o      = any_err & resp_valid;
  assign lsu_mcause_o        = !any_err ? 6'd0 :
                               we_q ? lsu_pkg::ExcStoreFault : lsu_pkg::ExcLoadFault;
  assign handle_misaligned_o = handle_misaligned_q;
  assign busy_o              = (ls_fsm_cs != lsu_pkg::IDLE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ls_fsm_cs           <= lsu_pkg::IDLE;
      handle_misaligned_q <= 1'b0;
      pmp_err_q           <= 1'b0;
      lsu_err_q           <= 1'b0;
      we_q                <= 1'b0;
      outstanding_resp_q  <= 1'b0;
    end else begin
      ls_fsm_cs           <= ls_fsm_ns;
      handle_misaligned_q <= handle_misaligned_d;
      pmp_err_q           <= pmp_err_d;
      lsu_err_q           <= lsu_err_d;
      if (lsu_go) begin
        we_q               <= lsu_we_i;
        outstanding_resp_q <= 1'b1;
      end else if (resp_valid) begin
        outstanding_resp_q <= 1'b0;
      end
    end
  end

  a_no_req_without_rdy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ls_fsm_cs == lsu_pkg::IDLE && !ds_rdy_i) |-> !data_req_o);

  a_legal_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ls_fsm_cs inside {lsu_pkg::IDLE, lsu_pkg::WAIT_GNT_MIS, lsu_pkg::WAIT_RVALID_MIS,
                      lsu_pkg::WAIT_GNT, lsu_pkg::WAIT_RVALID_MIS_GNTS_DONE});

endmodule

// File: source/lsu_pkg.sv
/* Shared widths, encodings and cause codes of the load/store unit.
   Size code 2'b11 is accepted and handled as a byte access. */
package lsu_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int unsigned AddrW = 32;
  localparam int unsigned DataW = 32;
  localparam int unsigned BeW   = 4;

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////

  // access size, 2'b11 falls into the byte branches
  typedef enum logic [1:0] {
    WORD = 2'b00,
    HALF = 2'b01,
    BYTE = 2'b10
  } lsu_type_e;

  // request FSM state
  typedef enum logic [2:0] {
    IDLE                      = 3'd0,
    WAIT_GNT_MIS              = 3'd1,
    WAIT_RVALID_MIS           = 3'd2,
    WAIT_GNT                  = 3'd3,
    WAIT_RVALID_MIS_GNTS_DONE = 3'd4
  } ls_fsm_e;

  // exception causes
  localparam logic [5:0] ExcLoadFault  = 6'd5;
  localparam logic [5:0] ExcStoreFault = 6'd7;

endpackage

// File: source/lsu_rdata_align.sv
/* Load data merge and extension on the response side.
   Output is combinational on data_rdata_i and only meaningful with rvalid. */
`timescale 1ns/10ps

module lsu_rdata_align (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      ctrl_update_i,
  input  logic                      rdata_update_i,
  input  logic [1:0]                data_offset_i,
  input  lsu_pkg::lsu_type_e        lsu_type_i,
  input  logic                      lsu_sign_ext_i,
  input  logic [lsu_pkg::DataW-1:0] data_rdata_i,
  output logic [lsu_pkg::DataW-1:0] lsu_rdata_o
);

  logic [1:0]                offset_q;
  lsu_pkg::lsu_type_e        type_q;
  logic                      sign_ext_q;
  logic [lsu_pkg::DataW-1:8] rdata_q;

  logic [31:0] rdata_w;
  logic [15:0] rdata_h;
  logic [7:0]  rdata_b;

  //////////////////////////////////////////////////
  // capture
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= 2'b00;
      type_q     <= lsu_pkg::WORD;
      sign_ext_q <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q   <= data_offset_i;
      type_q     <= lsu_type_i;
      sign_ext_q <= lsu_sign_ext_i;
    end
  end

  // upper bytes of the first word of a split load
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= data_rdata_i[31:8];
    end
  end

  //////////////////////////////////////////////////
  // merge and extract
  //////////////////////////////////////////////////

  always_comb begin
    unique case (offset_q)
      2'b00:   rdata_w = data_rdata_i;
      2'b01:   rdata_w = {data_rdata_i[7:0],  rdata_q[31:8]};
      2'b10:   rdata_w = {data_rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    unique case (offset_q)
      2'b00:   rdata_h = data_rdata_i[15:0];
      2'b01:   rdata_h = data_rdata_i[23:8];
      2'b10:   rdata_h = data_rdata_i[31:16];
      default: rdata_h = {data_rdata_i[7:0], rdata_q[31:24]};  // crosses the word
    endcase
  end

  assign rdata_b = data_rdata_i[8*offset_q +: 8];

  // zero or sign extension by size
  always_comb begin
    unique case (type_q)
      lsu_pkg::WORD: lsu_rdata_o = rdata_w;
      lsu_pkg::HALF: lsu_rdata_o = {{16{sign_ext_q & rdata_h[15]}}, rdata_h};
      default:       lsu_rdata_o = {{24{sign_ext_q & rdata_b[7]}}, rdata_b};
    endcase
  end

endmodule

// File: source/lsu_wdata_align.sv
/* Byte enables and store-data rotation for the current bus part.
   Purely combinational; size 2'b11 is a byte. */
`timescale 1ns/10ps

module lsu_wdata_align (
  input  lsu_pkg::lsu_type_e        lsu_type_i,
  input  logic                      handle_misaligned_i,
  input  logic [1:0]                data_offset_i,
  input  logic [lsu_pkg::DataW-1:0] lsu_wdata_i,
  output logic [lsu_pkg::BeW-1:0]   data_be_o,
  output logic [lsu_pkg::DataW-1:0] data_wdata_o
);

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  always_comb begin
    unique case (lsu_type_i)
      lsu_pkg::WORD: begin
        if (!handle_misaligned_i) begin
          unique case (data_offset_i)
            2'b00:   data_be_o = 4'b1111;
            2'b01:   data_be_o = 4'b1110;
            2'b10:   data_be_o = 4'b1100;
            default: data_be_o = 4'b1000;
          endcase
        end else begin
          // upper bytes spill into the low lanes of the next word
          unique case (data_offset_i)
            2'b01:   data_be_o = 4'b0001;
            2'b10:   data_be_o = 4'b0011;
            2'b11:   data_be_o = 4'b0111;
            default: data_be_o = 4'b0000;
          endcase
        end
      end
      lsu_pkg::HALF: begin
        if (!handle_misaligned_i) begin
          unique case (data_offset_i)
            2'b00:   data_be_o = 4'b0011;
            2'b01:   data_be_o = 4'b0110;
            2'b10:   data_be_o = 4'b1100;
            default: data_be_o = 4'b1000;
          endcase
        end else begin
          data_be_o = 4'b0001;
        end
      end
      default: data_be_o = 4'b0001 << data_offset_i;
    endcase
  end

  // rotate left so byte 0 lands on the lane of the offset
  always_comb begin
    unique case (data_offset_i)
      2'b00:   data_wdata_o = lsu_wdata_i;
      2'b01:   data_wdata_o = {lsu_wdata_i[23:0], lsu_wdata_i[31:24]};
      2'b10:   data_wdata_o = {lsu_wdata_i[15:0], lsu_wdata_i[31:16]};
      default: data_wdata_o = {lsu_wdata_i[7:0],  lsu_wdata_i[31:8]};
    endcase
  end

  // only split accesses reach the second part, and those are never aligned
  always_comb begin
    a_second_part_offset: assert final (!(handle_misaligned_i && data_offset_i == 2'b00));
  end

endmodule

// File: verif/tb_clk_gen.sv
/* Free-running 100 ns clock; reset is low for the first 8 rising edges. */
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // release just after an edge so no flop sees it change at the edge
  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

// File: verif/tb_load_store_unit.sv
/* Rows run one at a time, each after the previous response has returned.
   The memory model covers byte addresses 0x00 to 0xff only. */
`timescale 1ns/10ps

module tb_load_store_unit;

  localparam int num_rows   = 23;
  localparam int max_cycles = 20 * num_rows + 8;

  localparam lsu_pkg::lsu_type_e sz_w = lsu_pkg::WORD;
  localparam lsu_pkg::lsu_type_e sz_h = lsu_pkg::HALF;
  localparam lsu_pkg::lsu_type_e sz_b = lsu_pkg::BYTE;
  localparam logic [5:0] ld_flt = lsu_pkg::ExcLoadFault;
  localparam logic [5:0] st_flt = lsu_pkg::ExcStoreFault;

  typedef struct packed {
    logic               we;
    lsu_pkg::lsu_type_e size;
    logic               sext;
    logic [31:0]        addr;
    logic [31:0]        wdata;
    logic               err;
    logic               pmp;
    logic [3:0]         hold;
    logic [1:0]         nreq;
    logic [3:0]         be0;
    logic [3:0]         be1;
    logic [31:0]        rdata;
    logic [5:0]         cause;
    logic [31:0]        mtval;
  } row_t;

  logic clk_i, rst_ni;
  logic lsu_req_i, lsu_we_i, lsu_sign_ext_i, ds_rdy_i;
  lsu_pkg::lsu_type_e lsu_type_i;
  logic [31:0] lsu_addr_i, lsu_wdata_i, lsu_rdata_o, lsu_mtval_o, addr_last_o;
  logic lsu_req_done_o, lsu_resp_valid_o, lsu_resp_err_o, busy_o;
  logic [5:0] lsu_mcause_o;
  logic data_req_o, data_gnt_i, data_rvalid_i, data_err_i, data_pmp_err_i, data_we_o;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i;
  logic [3:0] data_be_o;

  row_t rows [num_rows];
  logic [31:0] mem [64];
  logic [31:0] acc_addr [4];
  logic [3:0]  acc_be [4];
  logic [31:0] rng, rd, resp_rdata, resp_mtval, resp_last, a0;
  logic [5:0]  resp_cause;
  logic        resp_err, got_resp, cur_err, cur_pmp, acc, req_seen;
  int          nacc, cnt, errors, errs_before, failed_rows, done_cnt, k, r, i, b, cycles;

  tb_clk_gen i_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  load_store_unit i_dut (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // little-endian word assembled byte by byte from any byte address
  function automatic logic [31:0] bytewise_word(input logic [31:0] a);
    logic [31:0] w, wd, ba;
    int n;
    for (n = 0; n < 4; n++) begin
      ba = a + n;
      wd = mem[ba[7:2]];
      w[8*n +: 8] = wd[8*ba[1:0] +: 8];
    end
    return w;
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////

  initial begin
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    data_rdata_i  = '0;
    rng           = 32'd72693;
    cnt           = 0;
    for (i = 0; i < 64; i++) begin
      mem[i] = (32'(i) * 32'h0103_0507) ^ 32'ha5a5_5a5a;
    end
    forever begin
      @(negedge clk_i);
      acc      = data_req_o && data_gnt_i;
      req_seen = data_req_o;
      if (acc) begin
        if (nacc < 4) begin
          acc_addr[nacc] = data_addr_o;
          acc_be[nacc]   = data_be_o;
        end
        nacc++;
        rd = mem[data_addr_o[7:2]];
        for (b = 0; b < 4; b++) begin
          if (data_we_o && !cur_err && data_be_o[b]) begin
            mem[data_addr_o[7:2]][8*b +: 8] = data_wdata_o[8*b +: 8];
          end
        end
      end
      @(posedge clk_i);
      #1;
      data_rvalid_i = acc;
      data_err_i    = acc && cur_err;
      data_rdata_i  = acc ? rd : '0;
      // next grant comes 0 to 2 requesting cycles later
      if (acc) begin
        rng = xorshift32(rng);
        cnt = rng % 3;
      end else if (req_seen && cnt != 0) begin
        cnt--;
      end
      data_gnt_i = (cnt == 0) && !cur_pmp;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timed out waiting for a response after %0d cycles", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // stimulus and checks
  //////////////////////////////////////////////////

  initial begin
    lsu_req_i = 1'b0;
    lsu_we_i = 1'b0;
    lsu_type_i = lsu_pkg::WORD;
    lsu_sign_ext_i = 1'b0;
    lsu_addr_i = '0;
    lsu_wdata_i = '0;
    ds_rdy_i = 1'b1;
    data_pmp_err_i = 1'b0;
    cur_err = 1'b0;
    cur_pmp = 1'b0;
    errors = 0;
    failed_rows = 0;
    cycles = 0;
    nacc = 0;
    // we sz  sx addr  wdata        er pm hd n  be0  be1  rdata        cause   mtval
    rows[0]  = '{1, sz_w, 0, 'h10, 'h8877_6655, 0, 0, 0, 1, 'hf, 'h0, 'h0,         0, 'h10};
    rows[1]  = '{0, sz_w, 0, 'h10, 'h0,         0, 0, 0, 1, 'hf, 'h0, 'h8877_6655, 0, 'h10};
    rows[2]  = '{0, sz_b, 1, 'h13, 'h0,         0, 0, 0, 1, 'h8, 'h0, 'hffff_ff88, 0, 'h13};
    rows[3]  = '{0, sz_b, 0, 'h13, 'h0,         0, 0, 3, 1, 'h8, 'h0, 'h0000_0088, 0, 'h13};
    rows[4]  = '{0, sz_b, 1, 'h11, 'h0,         0, 0, 0, 1, 'h2, 'h0, 'h0000_0066, 0, 'h11};
    rows[5]  = '{0, sz_h, 1, 'h12, 'h0,         0, 0, 0, 1, 'hc, 'h0, 'hffff_8877, 0, 'h12};
    rows[6]  = '{0, sz_h, 0, 'h11, 'h0,         0, 0, 0, 1, 'h6, 'h0, 'h0000_7766, 0, 'h11};
    rows[7]  = '{0, sz_h, 1, 'h10, 'h0,         0, 0, 0, 1, 'h3, 'h0, 'h0000_6655, 0, 'h10};
    rows[8]  = '{1, sz_b, 0, 'h12, 'h0000_00a1, 0, 0, 0, 1, 'h4, 'h0, 'h0,         0, 'h12};
    rows[9]  = '{0, sz_w, 0, 'h10, 'h0,         0, 0, 0, 1, 'hf, 'h0, 'h88a1_6655, 0, 'h10};
    rows[10] = '{0, sz_b, 1, 'h12, 'h0,         0, 0, 0, 1, 'h4, 'h0, 'hffff_ffa1, 0, 'h12};
    rows[11] = '{0, sz_b, 0, 'h10, 'h0,         0, 0, 0, 1, 'h1, 'h0, 'h0000_0055, 0, 'h10};
    rows[12] = '{1, sz_w, 0, 'h16, 'hddcc_bbaa, 0, 0, 0, 2, 'hc, 'h3, 'h0,         0, 'h18};
    rows[13] = '{0, sz_w, 0, 'h16, 'h0,         0, 0, 0, 2, 'hc, 'h3, 'hddcc_bbaa, 0, 'h18};
    rows[14] = '{1, sz_w, 0, 'h1d, 'h4433_2211, 0, 0, 0, 2, 'he, 'h1, 'h0,         0, 'h20};
    rows[15] = '{0, sz_w, 0, 'h1d, 'h0,         0, 0, 0, 2, 'he, 'h1, 'h4433_2211, 0, 'h20};
    rows[16] = '{1, sz_w, 0, 'h2b, 'h0d0c_0b0a, 0, 0, 0, 2, 'h8, 'h7, 'h0,         0, 'h2c};
    rows[17] = '{0, sz_w, 0, 'h2b, 'h0,         0, 0, 0, 2, 'h8, 'h7, 'h0d0c_0b0a, 0, 'h2c};
    rows[18] = '{0, sz_h, 1, 'h17, 'h0,         0, 0, 0, 2, 'h8, 'h1, 'hffff_ccbb, 0, 'h18};
    rows[19] = '{0, sz_w, 0, 'h30, 'h0,         1, 0, 2, 1, 'hf, 'h0, 'h0,    ld_flt, 'h30};
    rows[20] = '{1, sz_w, 0, 'h34, 'h1,         1, 0, 0, 1, 'hf, 'h0, 'h0,    st_flt, 'h34};
    rows[21] = '{0, sz_w, 0, 'h38, 'h0,         0, 1, 0, 0, 'h0, 'h0, 'h0,    ld_flt, 'h38};
    rows[22] = '{0, sz_w, 0, 'h10, 'h0,         0, 0, 2, 1, 'hf, 'h0, 'h88a1_6655, 0, 'h10};

    @(posedge rst_ni);
    @(negedge clk_i);
    check_equal(data_req_o, 0, "data_req_o after reset");
    check_equal(lsu_req_done_o, 0, "lsu_req_done_o after reset");
    check_equal(lsu_resp_valid_o, 0, "lsu_resp_valid_o after reset");
    check_equal(busy_o, 0, "busy_o after reset");

    for (r = 0; r < num_rows; r++) begin
      @(posedge clk_i);
      #1;
      // bus behavior is set a cycle before the request rises
      cur_err = rows[r].err;
      cur_pmp = rows[r].pmp;
      data_pmp_err_i = rows[r].pmp;
      nacc = 0;
      errs_before = errors;
      @(posedge clk_i);
      #1;
      lsu_req_i = 1'b1;
      lsu_we_i = rows[r].we;
      lsu_type_i = rows[r].size;
      lsu_sign_ext_i = rows[r].sext;
      lsu_addr_i = rows[r].addr;
      lsu_wdata_i = rows[r].wdata;
      ds_rdy_i = (rows[r].hold == 0);
      k = 0;
      done_cnt = 0;
      got_resp = 1'b0;
      while (!got_resp) begin
        @(negedge clk_i);
        if (!ds_rdy_i) begin
          check_equal(data_req_o, 0, "data_req_o with ds_rdy_i low");
          check_equal(lsu_req_done_o, 0, "lsu_req_done_o with ds_rdy_i low");
        end
        if (lsu_req_done_o) done_cnt++;
        if (lsu_resp_valid_o) begin
          got_resp   = 1'b1;
          resp_rdata = lsu_rdata_o;
          resp_err   = lsu_resp_err_o;
          resp_cause = lsu_mcause_o;
          resp_mtval = lsu_mtval_o;
          resp_last  = addr_last_o;
        end
        @(posedge clk_i);
        #1;
        k++;
        if (done_cnt != 0) lsu_req_i = 1'b0;
        ds_rdy_i = (k >= rows[r].hold);
      end

      a0 = {rows[r].addr[31:2], 2'b00};
      check_equal(done_cnt, 1, "done pulses");
      check_equal(nacc, rows[r].nreq, "bus requests");
      if (rows[r].nreq >= 1) begin
        check_equal(acc_addr[0], a0, "first bus address");
        check_equal(acc_be[0], rows[r].be0, "first byte enables");
      end
      if (rows[r].nreq == 2) begin
        check_equal(acc_addr[1], a0 + 4, "second bus address");
        check_equal(acc_be[1], rows[r].be1, "second byte enables");
      end
      check_equal(resp_err, rows[r].err | rows[r].pmp, "lsu_resp_err_o");
      check_equal(resp_cause, rows[r].cause, "lsu_mcause_o");
      check_equal(resp_mtval, rows[r].mtval, "lsu_mtval_o");
      check_equal(resp_last, rows[r].mtval, "addr_last_o");
      if (!rows[r].we && !rows[r].err && !rows[r].pmp) begin
        check_equal(resp_rdata, rows[r].rdata, "lsu_rdata_o");
        if (rows[r].size == sz_w) begin
          check_equal(resp_rdata, bytewise_word(rows[r].addr), "byte-wise memory read");
        end
      end
      if (errors == errs_before) begin
        $display("row %0d ok", r);
      end else begin
        $display("row %0d failed", r);
        failed_rows++;
      end
    end

    $display("%0d rows run, %0d failed, %0d mismatches", num_rows, failed_rows, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
